// ==== sources.f ====
+incdir+hw
hw/gamePkg.sv
hw/frameCapture.sv
hw/zombieContact.sv
hw/hitDetect.sv
hw/gameState.sv
hw/gameCore.sv
verif/tbClock.sv
verif/gameCoreTb.sv

// ==== runSim.sh ====
#!/bin/sh
# Compiles the core and its testbench with Verilator, runs it,
# and decides pass or fail from the simulation log.

cd "$(dirname "$0")" || exit 1

rm -rf obj_dir sim.log

verilator --binary --timing --assert -Wno-fatal \
  -f sources.f --top-module gameCoreTb -o simGameCore
if [ $? -ne 0 ]; then
  echo "Compile failed"
  exit 1
fi

./obj_dir/simGameCore > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if grep -qx "RESULT: PASS" sim.log; then
  exit 0
fi
echo "Pass message not found in sim.log"
exit 1

// ==== verif/gameCoreTb.sv ====
// Testbench for the collision and damage core
// Random frames from an LFSR, a reference model of the game rules,
// and a check of every output on every cycle

`timescale 1ns/1ns

`include "gameSettings.svh"

module gameCoreTb
  import gamePkg::*;
();

  localparam int Frames2 = 60;
  localparam int Frames4 = 40;
  // Random gaps of up to 3 idle cycles plus drains and a margin
  localparam int TimeoutCycles = 20 + Frames2 * 5 + 24 * 2 + Frames4 * 2 + 16 * 3 + 60 + 100;

  logic Clk, rstN, frameTick, newGame, bulletLive;
  coordT shooterX, shooterY, bulletX, bulletY;
  coordT [`NUM_ZOMBIES-1:0] zombieX, zombieY;
  barrierMapT barrierMap;
  logic removeBullet, shooterDamage, gameOver;
  zombieMaskT zombieKilled, zombieAlive;
  healthT shooterHealth;

  zombieMaskT modelAlive;
  healthT modelHealth;
  logic modelOver;
  int cycle, checkCount, errCount, errBefore, clockCount;
  logic [31:0] lfsr;
  int dueQ[$];          // Cycle at which each queued frame lands
  hitResultT hitQ[$];

  tbClock clock_i (.Clk, .rstN);

  gameCore dut_i (.*);

  function automatic logic [31:0] lfsrNext(input logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};   // Taps 32, 22, 2, 1
  endfunction

  function logic [31:0] randBits(input int n);
    logic [31:0] r;
    r = '0;
    for (int i = 0; i < n; i++)
    begin
      lfsr = lfsrNext(lfsr);
      r = {r[30:0], lfsr[0]};
    end
    return r;
  endfunction

  // A zombie corner on one of the four shooter centre pixels
  function automatic logic cornerContact(input coordT sx, input coordT sy,
                                         input coordT zx, input coordT zy);
    coordT midX, midY, farX, farY;
    midX = sx + coordT'(`SPRITE_HALF);
    midY = sy + coordT'(`SPRITE_HALF);
    farX = zx + coordT'(`SPRITE_FULL);
    farY = zy + coordT'(`SPRITE_FULL);
    return (farX == midX && farY == midY) || (farX == midX && zy == midY + coordT'(1))
        || (zx == midX + coordT'(1) && farY == midY)
        || (zx == midX + coordT'(1) && zy == midY + coordT'(1));
  endfunction

  function automatic hitResultT predictHits();
    hitResultT h;
    coordT farX, farY, row, col;
    h = '0;
    for (int i = 0; i < `NUM_ZOMBIES; i++)
    begin
      farX = zombieX[i] + coordT'(`SPRITE_FULL);
      farY = zombieY[i] + coordT'(`SPRITE_FULL);
      h.zombieHitMask[i] = bulletLive && bulletX >= zombieX[i] && bulletX <= farX
                        && bulletY >= zombieY[i] && bulletY <= farY;
      h.contactMask[i] = cornerContact(shooterX, shooterY, zombieX[i], zombieY[i]);
    end
    h.wallHit = bulletLive && ((bulletY + coordT'(`BULLET_SIZE) >= coordT'(`BULLET_Y_MAX))
             || (bulletY <= coordT'(`BULLET_Y_MIN + `BULLET_SIZE))
             || (bulletX + coordT'(`BULLET_SIZE) >= coordT'(`BULLET_X_MAX))
             || (bulletX <= coordT'(`BULLET_X_MIN + `BULLET_SIZE)));
    row = bulletY >> `TILE_SHIFT;
    col = bulletX >> `TILE_SHIFT;
    if (bulletLive && row < coordT'(`MAP_ROWS) && col < coordT'(`MAP_COLS))
      h.barrierHit = barrierMap[row[3:0]][col[4:0]] != tileT'(0);
    return h;
  endfunction

  task automatic checkValue(input string name, input logic [31:0] got, input logic [31:0] exp);
    checkCount++;
    assert (got === exp)
    else
    begin
      $display("FAIL %s got 0x%0h expected 0x%0h at cycle %0d", name, got, exp, cycle);
      errCount++;
    end
  endtask

  // Advances the model by one edge and compares every output
  task automatic checkOutputs();
    logic hasFrame, expRemove, expDamage;
    zombieMaskT kill;
    healthT healthNext;
    hitResultT h;
    hasFrame = 1'b0;
    expRemove = 1'b0;
    expDamage = 1'b0;
    kill = '0;
    h = '0;
    if (dueQ.size() > 0 && dueQ[0] == cycle)
    begin
      h = hitQ.pop_front();
      void'(dueQ.pop_front());
      hasFrame = 1'b1;
    end
    if (newGame)
    begin
      modelAlive = '1;   // Landing frame is dropped
      modelHealth = healthT'(`MAX_HEALTH);
      modelOver = 1'b0;
    end
    else if (hasFrame)
    begin
      kill = h.zombieHitMask & modelAlive;
      expRemove = h.wallHit || h.barrierHit || (kill != '0);
      expDamage = ((h.contactMask & modelAlive) != '0) && !modelOver;
      healthNext = (expDamage && modelHealth != 0) ? modelHealth - healthT'(1) : modelHealth;
      modelAlive = modelAlive & ~kill;
      modelHealth = healthNext;
      modelOver = (healthNext == 0);
    end
    checkValue("removeBullet", 32'(removeBullet), 32'(expRemove));
    checkValue("zombieKilled", 32'(zombieKilled), 32'(kill));
    checkValue("shooterDamage", 32'(shooterDamage), 32'(expDamage));
    checkValue("zombieAlive", 32'(zombieAlive), 32'(modelAlive));
    checkValue("shooterHealth", 32'(shooterHealth), 32'(modelHealth));
    checkValue("gameOver", 32'(gameOver), 32'(modelOver));
  endtask

  task automatic stepCycle();
    @(posedge Clk);
    #10;
    cycle++;
    checkOutputs();
    frameTick = 1'b0;
    newGame = 1'b0;
  endtask

  task automatic sendFrame();
    frameTick = 1'b1;
    hitQ.push_back(predictHits());
    dueQ.push_back(cycle + 3);
  endtask

  task automatic drain();
    repeat (4) stepCycle();
  endtask

  task automatic parkZombies();
    for (int i = 0; i < `NUM_ZOMBIES; i++)
    begin
      zombieX[i] = coordT'(900);   // Away from the bullet and shooter
      zombieY[i] = coordT'(900);
    end
  endtask

  task automatic wallShot(input int x, input int y);
    bulletX = coordT'(x);
    bulletY = coordT'(y);
    sendFrame();
    stepCycle();
  endtask

  task automatic reportTest(input string name);
    $display("%s: %s", name, (errCount == errBefore) ? "ok" : "failed");
    errBefore = errCount;
  endtask

  // Watchdog on a free-running edge count
  always @(posedge Clk)
  begin
    clockCount++;
    if (clockCount > TimeoutCycles)
    begin
      $display("Timeout after %0d cycles, the run did not finish", TimeoutCycles);
      $display("RESULT: FAIL");
      $finish;
    end
  end

  initial
  begin
    lfsr = 32'h606f_5187;
    {cycle, checkCount, errCount, errBefore, clockCount} = '0;
    {frameTick, newGame, bulletLive} = '0;
    shooterX = coordT'(100);
    shooterY = coordT'(100);
    bulletX = coordT'(320);
    bulletY = coordT'(256);
    parkZombies();
    barrierMap = '0;
    modelAlive = '1;
    modelHealth = healthT'(`MAX_HEALTH);
    modelOver = 1'b0;
    @(posedge rstN);

    stepCycle();
    reportTest("test 1 reset state");

    for (int f = 0; f < Frames2; f++)
    begin
      shooterX = coordT'(randBits(10));
      shooterY = coordT'(randBits(10));
      bulletX = coordT'(randBits(10));
      bulletY = coordT'(randBits(10));
      bulletLive = randBits(3) != 0;
      for (int i = 0; i < `NUM_ZOMBIES; i++)
      begin
        zombieX[i] = randBits(1) ? bulletX - coordT'(randBits(6)) : coordT'(randBits(10));
        zombieY[i] = randBits(1) ? bulletY - coordT'(randBits(6)) : coordT'(randBits(10));
      end
      sendFrame();
      stepCycle();
      repeat (randBits(2)) stepCycle();   // Zero gap gives back-to-back frames
    end
    drain();
    reportTest("test 2 random kills");

    parkZombies();
    shooterX = coordT'(100);
    shooterY = coordT'(100);
    for (int live = 1; live >= 0; live--)
    begin
      bulletLive = live[0];
      for (int k = 0; k < 3; k++)
      begin
        wallShot(320, 442 + k);
        wallShot(320, 67 + k);
        wallShot(602 + k, 256);
        wallShot(35 + k, 256);
      end
    end
    drain();
    reportTest("test 3 wall bounds");

    for (int r = 0; r < `MAP_ROWS; r++)
      for (int c = 0; c < `MAP_COLS; c++)
        barrierMap[r][c] = tileT'(randBits(2));
    for (int f = 0; f < Frames4; f++)
    begin
      bulletX = coordT'(randBits(10));   // Reaches past the map edges
      bulletY = coordT'(randBits(10));
      bulletLive = randBits(2) != 0;
      sendFrame();
      stepCycle();
      stepCycle();
    end
    drain();
    barrierMap = '0;
    reportTest("test 4 barrier map");

    newGame = 1'b1;
    stepCycle();
    bulletLive = 1'b0;
    shooterX = coordT'(200);
    shooterY = coordT'(200);
    for (int k = 0; k < 16; k++)
    begin
      parkZombies();
      // Corners 184 and 216 sit on the centre pixels 215 and 216
      zombieX[k % `NUM_ZOMBIES] = coordT'((k % 4 < 2) ? 184 : 216) + coordT'(k / 4 % 2);
      zombieY[k % `NUM_ZOMBIES] = coordT'((k % 2 == 0) ? 184 : 216);
      sendFrame();
      stepCycle();
      stepCycle();
    end
    drain();
    checkValue("gameOver", 32'(gameOver), 32'(1));
    reportTest("test 5 contact damage");

    parkZombies();
    zombieX[3] = coordT'(184);
    zombieY[3] = coordT'(184);
    bulletLive = 1'b1;
    bulletX = coordT'(190);
    bulletY = coordT'(190);
    sendFrame();
    stepCycle();
    stepCycle();
    newGame = 1'b1;   // Lands on the same edge as that frame
    stepCycle();
    checkValue("shooterHealth", 32'(shooterHealth), 32'(`MAX_HEALTH));
    drain();
    reportTest("test 6 new game");

    $display("Checks: %0d, errors: %0d", checkCount, errCount);
    if (errCount == 0)
      $display("RESULT: PASS");
    else
      $display("RESULT: FAIL");
    $finish;
  end

endmodule

// ==== verif/tbClock.sv ====
// Testbench clock and reset generator
// 100 ns clock, reset held low for the first three cycles

`timescale 1ns/1ns

module tbClock
(
  output logic Clk,
  output logic rstN
);

  initial
  begin
    Clk = 1'b0;
    forever #50 Clk = ~Clk;
  end

  initial
  begin
    rstN = 1'b0;
    repeat (3) @(posedge Clk);
    #10 rstN = 1'b1;   // Released clear of the edge
  end

endmodule

// ==== hw/gameCore.sv ====
// Collision and damage core for the zombie shooter
// Capture, hit detection and game state, one cycle per stage

`timescale 1ns/1ns

`include "gameSettings.svh"

module gameCore
  import gamePkg::*;
(
  input  logic                     Clk,
  input  logic                     rstN,
  input  logic                     frameTick,
  input  logic                     newGame,
  input  coordT                    shooterX,
  input  coordT                    shooterY,
  input  coordT                    bulletX,
  input  coordT                    bulletY,
  input  logic                     bulletLive,
  input  coordT [`NUM_ZOMBIES-1:0] zombieX,
  input  coordT [`NUM_ZOMBIES-1:0] zombieY,
  input  barrierMapT               barrierMap,   // Held stable while frames are in flight
  output logic                     removeBullet,
  output zombieMaskT               zombieKilled,
  output logic                     shooterDamage,
  output zombieMaskT               zombieAlive,
  output healthT                   shooterHealth,
  output logic                     gameOver
);

  frameSnapT snap;
  logic      snapValid;
  hitResultT hits;
  logic      hitValid;

  frameCapture capture_i (
    .Clk, .rstN, .frameTick,
    .shooterX, .shooterY, .bulletX, .bulletY, .bulletLive,
    .zombieX, .zombieY,
    .snap, .snapValid
  );

  hitDetect detect_i (
    .Clk, .rstN, .snap, .snapValid, .barrierMap,
    .hits, .hitValid
  );

  gameState state_i (
    .Clk, .rstN, .newGame, .hits, .hitValid,
    .removeBullet, .zombieKilled, .shooterDamage,
    .zombieAlive, .shooterHealth, .gameOver
  );

endmodule

// ==== hw/gameState.sv ====
// Game state, third pipeline stage
// Tracks live zombies, shooter health and game over, and turns each
// frame's hits into one-cycle outcome pulses

`timescale 1ns/1ns

`include "gameSettings.svh"

module gameState
  import gamePkg::*;
(
  input  logic       Clk,
  input  logic       rstN,
  input  logic       newGame,
  input  hitResultT  hits,
  input  logic       hitValid,
  output logic       removeBullet,
  output zombieMaskT zombieKilled,
  output logic       shooterDamage,
  output zombieMaskT zombieAlive,
  output healthT     shooterHealth,
  output logic       gameOver
);

  zombieMaskT killComb;
  logic       damageComb;
  healthT     healthNext;

  // Dead zombies neither die again nor bite
  assign killComb   = hits.zombieHitMask & zombieAlive;
  assign damageComb = (|(hits.contactMask & zombieAlive)) && !gameOver;

  // Saturates at zero
  assign healthNext = (damageComb && (shooterHealth != healthT'(0)))
                    ? shooterHealth - healthT'(1)
                    : shooterHealth;

  always_ff @(posedge Clk or negedge rstN)
  begin
    if (!rstN)
    begin
      removeBullet  <= 1'b0;
      zombieKilled  <= '0;
      shooterDamage <= 1'b0;
      zombieAlive   <= '1;
      shooterHealth <= healthT'(`MAX_HEALTH);
      gameOver      <= 1'b0;
    end
    else
    begin
      removeBullet  <= 1'b0;   // Pulses drop unless a frame lands
      zombieKilled  <= '0;
      shooterDamage <= 1'b0;
      if (newGame)
      begin
        // Fresh game, this cycle's frame is discarded
        zombieAlive   <= '1;
        shooterHealth <= healthT'(`MAX_HEALTH);
        gameOver      <= 1'b0;
      end
      else if (hitValid)
      begin
        removeBullet  <= hits.wallHit || hits.barrierHit || (|killComb);
        zombieKilled  <= killComb;
        shooterDamage <= damageComb;
        zombieAlive   <= zombieAlive & ~killComb;
        shooterHealth <= healthNext;
        gameOver      <= (healthNext == healthT'(0));
      end
    end
  end

endmodule

// ==== hw/hitDetect.sv ====
// Hit detection, second pipeline stage
// Finds bullet hits on zombies, walls and barrier tiles, plus zombie
// contacts on the shooter, and registers them as one frame result

`timescale 1ns/1ns

`include "gameSettings.svh"

module hitDetect
  import gamePkg::*;
(
  input  logic       Clk,
  input  logic       rstN,
  input  frameSnapT  snap,
  input  logic       snapValid,
  input  barrierMapT barrierMap,
  output hitResultT  hits,
  output logic       hitValid
);

  localparam int RowW = $clog2(`MAP_ROWS);
  localparam int ColW = $clog2(`MAP_COLS);

  zombieMaskT      zombieHitComb;
  zombieMaskT      contactComb;
  coordT           bulletRight;
  coordT           bulletBottom;
  logic            wallComb;
  coordT           tileRow;
  coordT           tileCol;
  logic [RowW-1:0] rowIdx;
  logic [ColW-1:0] colIdx;
  logic            inMap;
  tileT            tileCode;
  logic            barrierComb;

  // Bullet inside a zombie box, edges inclusive
  always_comb
  begin
    coordT xMax;
    coordT yMax;
    zombieHitComb = '0;
    for (int i = 0; i < `NUM_ZOMBIES; i++)
    begin
      xMax = snap.zombieX[i] + coordT'(`SPRITE_FULL);
      yMax = snap.zombieY[i] + coordT'(`SPRITE_FULL);
      zombieHitComb[i] = snap.bulletLive
                      && (snap.bulletX >= snap.zombieX[i]) && (snap.bulletX <= xMax)
                      && (snap.bulletY >= snap.zombieY[i]) && (snap.bulletY <= yMax);
    end
  end

  // Screen walls
  assign bulletRight  = snap.bulletX + coordT'(`BULLET_SIZE);
  assign bulletBottom = snap.bulletY + coordT'(`BULLET_SIZE);
  assign wallComb = snap.bulletLive
                 && ((bulletBottom >= coordT'(`BULLET_Y_MAX))
                  || (snap.bulletY <= coordT'(`BULLET_Y_MIN + `BULLET_SIZE))
                  || (bulletRight >= coordT'(`BULLET_X_MAX))
                  || (snap.bulletX <= coordT'(`BULLET_X_MIN + `BULLET_SIZE)));

  // Barrier tile under the bullet, nothing solid outside the map
  assign tileRow  = snap.bulletY >> `TILE_SHIFT;
  assign tileCol  = snap.bulletX >> `TILE_SHIFT;
  assign rowIdx   = tileRow[RowW-1:0];
  assign colIdx   = tileCol[ColW-1:0];
  assign inMap    = (tileRow < coordT'(`MAP_ROWS)) && (tileCol < coordT'(`MAP_COLS));
  assign tileCode = inMap ? barrierMap[rowIdx][colIdx] : tileT'(0);
  assign barrierComb = snap.bulletLive && (tileCode != tileT'(0));

  // One contact checker per zombie, independent of the bullet
  for (genvar g = 0; g < `NUM_ZOMBIES; g++)
  begin : gContact
    zombieContact contact_i (
      .shooterX (snap.shooterX),
      .shooterY (snap.shooterY),
      .zombieX  (snap.zombieX[g]),
      .zombieY  (snap.zombieY[g]),
      .contact  (contactComb[g])
    );
  end

  always_ff @(posedge Clk)
  begin
    if (snapValid)
    begin
      hits.zombieHitMask <= zombieHitComb;
      hits.contactMask   <= contactComb;
      hits.wallHit       <= wallComb;
      hits.barrierHit    <= barrierComb;
    end
  end

  always_ff @(posedge Clk or negedge rstN)
  begin
    if (!rstN)
    begin
      hitValid <= 1'b0;
    end
    else
    begin
      hitValid <= snapValid;
    end
  end

endmodule

// ==== hw/zombieContact.sv ====
// Zombie to shooter contact test
// Flags a zombie corner sitting on one of the four shooter centre pixels

`timescale 1ns/1ns

`include "gameSettings.svh"

module zombieContact
  import gamePkg::*;
(
  input  coordT shooterX,
  input  coordT shooterY,
  input  coordT zombieX,
  input  coordT zombieY,
  output logic  contact
);

  coordT zombieRight;    // Far edges of the zombie box
  coordT zombieBottom;
  coordT centreX;        // Upper-left centre pixel of the shooter
  coordT centreY;
  coordT centreX1;       // Lower-right centre pixel
  coordT centreY1;

  // All sums wrap at the coordinate width
  assign zombieRight  = zombieX + coordT'(`SPRITE_FULL);
  assign zombieBottom = zombieY + coordT'(`SPRITE_FULL);
  assign centreX      = shooterX + coordT'(`SPRITE_HALF);
  assign centreY      = shooterY + coordT'(`SPRITE_HALF);
  assign centreX1     = centreX + coordT'(1);
  assign centreY1     = centreY + coordT'(1);

  assign contact = ((zombieRight == centreX)  && (zombieBottom == centreY))   // Bottom-right
                || ((zombieRight == centreX)  && (zombieY == centreY1))       // Top-right
                || ((zombieX == centreX1)     && (zombieBottom == centreY))   // Bottom-left
                || ((zombieX == centreX1)     && (zombieY == centreY1));      // Top-left

endmodule

// ==== hw/frameCapture.sv ====
// Frame capture, first pipeline stage
// Samples the shooter, bullet and zombie positions on the frame strobe

`timescale 1ns/1ns

`include "gameSettings.svh"

module frameCapture
  import gamePkg::*;
(
  input  logic                     Clk,
  input  logic                     rstN,
  input  logic                     frameTick,
  input  coordT                    shooterX,
  input  coordT                    shooterY,
  input  coordT                    bulletX,
  input  coordT                    bulletY,
  input  logic                     bulletLive,
  input  coordT [`NUM_ZOMBIES-1:0] zombieX,
  input  coordT [`NUM_ZOMBIES-1:0] zombieY,
  output frameSnapT                snap,
  output logic                     snapValid
);

  // Snapshot payload, only loaded on a frame strobe
  always_ff @(posedge Clk)
  begin
    if (frameTick)
    begin
      snap.shooterX   <= shooterX;
      snap.shooterY   <= shooterY;
      snap.bulletX    <= bulletX;
      snap.bulletY    <= bulletY;
      snap.bulletLive <= bulletLive;
      snap.zombieX    <= zombieX;
      snap.zombieY    <= zombieY;
    end
  end

  // Valid lines up with the loaded snapshot
  always_ff @(posedge Clk or negedge rstN)
  begin
    if (!rstN)
    begin
      snapValid <= 1'b0;
    end
    else
    begin
      snapValid <= frameTick;
    end
  end

endmodule

// ==== hw/gamePkg.sv ====
// Shared types for the collision core
// Coordinates, barrier tiles, zombie masks and the stage payloads

`include "gameSettings.svh"

package gamePkg;

  typedef logic [`COORD_W-1:0] coordT;
  typedef logic [`TILE_W-1:0] tileT;   // Nonzero means solid

  // Row-major map, index as map[row][col]
  typedef tileT [0:`MAP_ROWS-1][0:`MAP_COLS-1] barrierMapT;

  typedef logic [`NUM_ZOMBIES-1:0] zombieMaskT;   // One bit per zombie
  typedef logic [`HEALTH_W-1:0] healthT;

  // Positions sampled on a frame strobe
  typedef struct packed {
    coordT                     shooterX;
    coordT                     shooterY;
    coordT                     bulletX;
    coordT                     bulletY;
    logic                      bulletLive;
    coordT [`NUM_ZOMBIES-1:0]  zombieX;
    coordT [`NUM_ZOMBIES-1:0]  zombieY;
  } frameSnapT;

  // Collision events found for one frame
  typedef struct packed {
    zombieMaskT zombieHitMask;   // Bullet inside a zombie box
    zombieMaskT contactMask;     // Zombie corner on the shooter centre
    logic       wallHit;
    logic       barrierHit;
  } hitResultT;

endpackage

// ==== hw/gameSettings.svh ====
// Game settings for the zombie collision core
// Screen bounds, sprite sizes and start values shared by every block

`ifndef GAME_SETTINGS_SVH
`define GAME_SETTINGS_SVH

// Field widths
`define COORD_W      10   // Screen coordinate bits
`define TILE_W       2    // Barrier tile code bits
`define HEALTH_W     3    // Shooter health bits

// Sprites
`define NUM_ZOMBIES  10
`define SPRITE_FULL  31   // Sprite size minus one
`define SPRITE_HALF  15
`define BULLET_SIZE  4

// Bullet wall bounds in pixels
`define BULLET_X_MIN 32
`define BULLET_X_MAX 607
`define BULLET_Y_MIN 64
`define BULLET_Y_MAX 447

// Barrier map, one tile is 32 x 32 pixels
`define TILE_SHIFT   5
`define MAP_ROWS     15
`define MAP_COLS     20

`define MAX_HEALTH   5    // Health at the start of a game

`endif
